/* sim.f */
rtl/mcd_pkg.sv
rtl/cpu_bus_decode.sv
rtl/dram_arbiter.sv
rtl/line_timer.sv
rtl/cpu_read_return.sv
rtl/mcd_dram.sv
bench/sdram_model.sv
bench/tb_mcd_asserts.sv
bench/tb_mcd.sv

/* Makefile */
# Verilator build and run of the DRAM front end testbench

TOP := tb_mcd

all: build run

build:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o $(TOP)

run: build
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "PASS: all tests"

lint:
	verilator --lint-only --timing -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

/* bench/tb_mcd.sv */
/*
 * Random CPU master against a shadow model of RAM, ROM fill and status register.
 * Strobes are watched at the falling edge, where all DUT outputs are settled.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_mcd;

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic [22:1] cpu_address = '0;
    logic [15:0] cpu_din = '0;
    logic cpu_uds = 1'b0;
    logic cpu_lds = 1'b0;
    logic cpu_write_strobe = 1'b0;
    logic cs = 1'b0;
    logic [15:0] cpu_dout;
    logic cpu_bus_ack;
    logic [24:0] sdram_addr;
    logic sdram_rd;
    logic sdram_wr;
    logic sdram_word;
    logic [15:0] sdram_din;
    logic [15:0] sdram_dout;
    logic sdram_busy;
    logic vblank;

    int seed = 58196;
    int cyc;
    int boot_seen = 0;
    logic [15:0] shadow [logic [23:0]];
    logic pending = 1'b0;
    logic strobe_seen = 1'b0;
    logic exp_wr;
    logic exp_word;
    logic [24:0] exp_addr;
    logic [15:0] exp_din;
    logic have_last = 1'b0;
    logic [24:0] last_rd;
    logic [21:0] pool [16];

    always #2 clk = ~clk;

    mcd_dram dut (.*);

    sdram_model u_sdram (.*);

    bind dram_arbiter tb_mcd_asserts u_asserts (.*);

    // same counting as a pixel counter that starts at 0 after reset
    always @(posedge clk) begin
        if (reset) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    task automatic fail_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_sdram_addr(input string name, input logic [24:0] got,
                                    input logic [24:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
            fail_run();
        end
    endtask

    function automatic logic [15:0] fill_word(input logic [23:0] wa);
        return wa[15:0] ^ {wa[23:16], wa[23:16]} ^ 16'h5A3C;
    endfunction

    function automatic logic [15:0] shadow_read(input logic [23:0] wa);
        return shadow.exists(wa) ? shadow[wa] : fill_word(wa);
    endfunction

    // strobe monitor: CPU strobes must match the request, the others are refresh rereads
    always @(negedge clk) begin
        if (!reset && sdram_wr) begin
            if (!pending || !exp_wr) begin
                $display("unexpected SDRAM write at %0t", $time);
                fail_run();
            end
            check_sdram_addr("sdram_addr", sdram_addr, exp_addr);
            check_flag("sdram_word", sdram_word, exp_word);
            check_word("sdram_din", sdram_din, exp_din);
            strobe_seen = 1'b1;
        end
        if (!reset && sdram_rd) begin
            if (pending && !exp_wr && !strobe_seen && sdram_addr == exp_addr) begin
                check_flag("sdram_word", sdram_word, exp_word);
                strobe_seen = 1'b1;
            end else if (have_last) begin
                check_sdram_addr("refresh sdram_addr", sdram_addr, last_rd);
            end
            last_rd = sdram_addr;
            have_last = 1'b1;
        end
    end

    task automatic cpu_access(input logic [22:1] a, input logic [15:0] d,
                              input logic u, input logic l, input logic w);
        logic [22:0] ba;
        logic is_sdram;
        logic is_status;
        logic [15:0] exp_data;
        logic [15:0] cur;
        int n;
        ba = {a, 1'b0};
        is_sdram = 1'b1;
        is_status = 1'b0;
        if (boot_seen < 4) begin
            exp_addr = {3'b001, a[21:1], 1'b0};
            exp_word = 1'b1;
            exp_wr = 1'b0;
        end else if (ba < 23'h40_0000) begin
            exp_addr = {5'b0, a[18], a[21], a[17:1], w && l && !u};
            exp_word = (u && l) || !w;
            exp_wr = w;
        end else if (ba < 23'h4F_FC00) begin
            exp_addr = {3'b001, a[21:1], 1'b0};
            exp_word = 1'b1;
            exp_wr = 1'b0;
        end else begin
            is_sdram = 1'b0;
            is_status = ba == 23'h4F_FFF0;
        end
        exp_din = d;
        @(posedge clk);
        pending = is_sdram;
        strobe_seen = 1'b0;
        cpu_address <= a;
        cpu_din <= d;
        cpu_uds <= u;
        cpu_lds <= l;
        cpu_write_strobe <= w;
        cs <= 1'b1;
        n = 0;
        @(negedge clk);
        if (!is_sdram) begin
            check_flag("cpu_bus_ack", cpu_bus_ack, 1'b1);
        end
        while (!cpu_bus_ack) begin
            n++;
            if (n > 500) begin
                $display("timeout waiting for cpu_bus_ack at %0t", $time);
                fail_run();
            end
            @(negedge clk);
        end
        if (is_sdram) begin
            if (!strobe_seen) begin
                $display("SDRAM access acknowledged without its strobe at %0t", $time);
                fail_run();
            end
            if (exp_wr) begin
                cur = shadow_read(exp_addr[24:1]);
                if (u) begin
                    cur[15:8] = d[15:8];
                end
                if (l) begin
                    cur[7:0] = d[7:0];
                end
                shadow[exp_addr[24:1]] = cur;
            end else begin
                check_word("cpu_dout", cpu_dout, shadow_read(exp_addr[24:1]));
            end
        end else if (!w) begin
            exp_data = 16'h0000;
            if (is_status) begin
                exp_data[7] = ((cyc / 200) % 12) < 10;
                check_flag("vblank", vblank, !exp_data[7]);
            end
            check_word("cpu_dout", cpu_dout, exp_data);
        end
        if (u && boot_seen < 4) begin
            boot_seen++;
        end
        pending = 1'b0;
        @(posedge clk);
        cs <= 1'b0;
        cpu_uds <= 1'b0;
        cpu_lds <= 1'b0;
        cpu_write_strobe <= 1'b0;
    endtask

    initial begin
        int r;
        int kind;
        logic u;
        logic l;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < 16; i++) begin
            pool[i] = {1'b0, 21'($random(seed))};
        end
        // boot swap, writes included, all land on ROM reads
        for (int i = 0; i < 4; i++) begin
            cpu_access(pool[i], 16'($random(seed)), 1'b1, i[0], i[1]);
        end
        for (int i = 0; i < 400; i++) begin
            r = $random(seed);
            kind = $unsigned(r) % 8;
            u = r[8];
            l = r[9] || !r[8];
            if (kind < 5) begin
                cpu_access(pool[r[15:12]], 16'($random(seed)), u, l, r[10]);
            end else if (kind == 5) begin
                cpu_access(22'h27_FFF8, 16'h0000, 1'b1, 1'b1, 1'b0);
            end else if (kind == 6) begin
                if (r[11]) begin
                    cpu_access(22'h27_FFFA, 16'h0000, u, l, 1'b0);
                end else begin
                    cpu_access(22'h27_FE00 + 22'(r[24:16]), 16'h0000, u, l, 1'b0);
                end
            end else begin
                cpu_access(22'h20_0000 + 22'(r[30:12]), 16'h0000, u, l, 1'b0);
            end
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/tb_mcd_asserts.sv */
/*
 * Arbiter protocol checks, bound into dram_arbiter.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_mcd_asserts
    import mcd_pkg::*;
(
    input wire logic   clk,
    input wire logic   reset,
    input wire owner_e owner,
    input wire logic   sdram_busy,
    input wire logic   sdram_rd,
    input wire logic   sdram_wr
);

    // owner that issued the access now in flight
    owner_e strobe_owner;

    always_ff @(posedge clk) begin
        if (reset) begin
            strobe_owner <= REFRESH;
        end else if (sdram_rd || sdram_wr) begin
            strobe_owner <= owner;
        end
    end

    owner_frozen: assert property (@(posedge clk) disable iff (reset)
        sdram_busy |-> owner == strobe_owner)
        else $error("owner changed while busy");

    one_strobe: assert property (@(posedge clk) disable iff (reset)
        !(sdram_rd && sdram_wr))
        else $error("read and write strobe together");

    no_strobe_busy: assert property (@(posedge clk) disable iff (reset)
        (sdram_rd || sdram_wr) |-> !sdram_busy && !$past(sdram_busy))
        else $error("strobe while busy or right after busy");

endmodule

`default_nettype wire

/* bench/sdram_model.sv */
/*
 * Behavioral SDRAM: busy lasts 1 to 3 cycles after a strobe, read data appears at its fall.
 * Unwritten words read back a fill pattern of the word address.
 */
`timescale 1ns/1ps
`default_nettype none

module sdram_model (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic [24:0] sdram_addr,
    input  wire logic        sdram_rd,
    input  wire logic        sdram_wr,
    input  wire logic        sdram_word,
    input  wire logic [15:0] sdram_din,
    output logic [15:0]      sdram_dout,
    output logic             sdram_busy
);

    logic [15:0] mem [logic [23:0]];
    int          seed = 58196;
    int          left;
    logic [15:0] rd_data;
    logic [15:0] cur;

    function automatic logic [15:0] fill_word(input logic [23:0] wa);
        return wa[15:0] ^ {wa[23:16], wa[23:16]} ^ 16'h5A3C;
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            sdram_busy <= 1'b0;
            sdram_dout <= 16'h0000;
            left = 0;
        end else if (sdram_rd || sdram_wr) begin
            sdram_busy <= 1'b1;
            left = 1 + ($unsigned($random(seed)) % 3);
            cur = mem.exists(sdram_addr[24:1]) ? mem[sdram_addr[24:1]]
                                               : fill_word(sdram_addr[24:1]);
            if (sdram_wr) begin
                if (sdram_word) begin
                    cur = sdram_din;
                end else if (sdram_addr[0]) begin
                    cur[7:0] = sdram_din[7:0];
                end else begin
                    cur[15:8] = sdram_din[15:8];
                end
                mem[sdram_addr[24:1]] = cur;
            end
            rd_data = cur;
        end else if (sdram_busy) begin
            left = left - 1;
            if (left == 0) begin
                sdram_busy <= 1'b0;
                sdram_dout <= rd_data;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/mcd_dram.sv */
/*
 * CPU-facing DRAM half of the system controller: decode, arbitration and read return.
 * The CPU holds each request until it sees the acknowledge.
 */
`timescale 1ns/1ps
`default_nettype none

module mcd_dram
    import mcd_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic [22:1] cpu_address,
    input  wire logic [15:0] cpu_din,
    input  wire logic        cpu_uds,
    input  wire logic        cpu_lds,
    input  wire logic        cpu_write_strobe,
    input  wire logic        cs,
    output logic [15:0]      cpu_dout,
    output logic             cpu_bus_ack,
    output logic [24:0]      sdram_addr,
    output logic             sdram_rd,
    output logic             sdram_wr,
    output logic             sdram_word,
    output logic [15:0]      sdram_din,
    input  wire logic [15:0] sdram_dout,
    input  wire logic        sdram_busy,
    output logic             vblank
);

    cpu_req_t  req;
    dram_req_t dreq;
    logic      refresh_window;

    assign req.addr  = cpu_address;
    assign req.din   = cpu_din;
    assign req.uds   = cpu_uds;
    assign req.lds   = cpu_lds;
    assign req.write = cpu_write_strobe;
    assign req.cs    = cs;

    cpu_bus_decode u_decode (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .ack   (cpu_bus_ack),
        .dreq  (dreq)
    );

    line_timer u_timer (
        .clk            (clk),
        .reset          (reset),
        .refresh_window (refresh_window),
        .vblank         (vblank)
    );

    dram_arbiter u_arbiter (
        .clk            (clk),
        .reset          (reset),
        .dreq           (dreq),
        .refresh_window (refresh_window),
        .sdram_busy     (sdram_busy),
        .sdram_addr     (sdram_addr),
        .sdram_rd       (sdram_rd),
        .sdram_wr       (sdram_wr),
        .sdram_word     (sdram_word),
        .sdram_din      (sdram_din),
        .ack            (cpu_bus_ack)
    );

    cpu_read_return u_return (
        .dreq       (dreq),
        .sdram_dout (sdram_dout),
        .vblank     (vblank),
        .cpu_dout   (cpu_dout)
    );

endmodule

`default_nettype wire

/* rtl/cpu_read_return.sv */
/*
 * CPU read data mux. Only the channel 1 status register returns anything on the I/O side.
 */
`timescale 1ns/1ps
`default_nettype none

module cpu_read_return
    import mcd_pkg::*;
(
    input  wire dram_req_t   dreq,
    input  wire logic [15:0] sdram_dout,
    input  wire logic        vblank,
    output logic [15:0]      cpu_dout
);

    always_comb begin
        cpu_dout = 16'h0000;

        case (dreq.target)
            T_RAM, T_ROM: begin
                cpu_dout = sdram_dout;
            end
            T_STATUS: begin
                // display active flag, all other status bits read as zero
                cpu_dout[STATUS_VBLANK_BIT] = !vblank;
            end
            default: begin
                cpu_dout = 16'h0000;
            end
        endcase
    end

endmodule

`default_nettype wire

/* rtl/line_timer.sv */
/*
 * Pixel and line counters with simulation-sized line and frame lengths.
 * The refresh window opens at the start of every line; vblank covers the last lines.
 */
`timescale 1ns/1ps
`default_nettype none

module line_timer
    import mcd_pkg::*;
(
    input  wire logic clk,
    input  wire logic reset,
    output logic      refresh_window,
    output logic      vblank
);

    logic [7:0] x;
    logic [3:0] line;
    logic       line_end;
    logic       frame_end;

    assign line_end  = x == LINE_CYCLES - 8'd1;
    assign frame_end = line == FRAME_LINES - 4'd1;

    always_ff @(posedge clk) begin
        if (reset) begin
            x    <= 8'd0;
            line <= 4'd0;
        end else if (line_end) begin
            x <= 8'd0;
            if (frame_end) begin
                line <= 4'd0;
            end else begin
                line <= line + 4'd1;
            end
        end else begin
            x <= x + 8'd1;
        end
    end

    // several refresh reads fit into each window
    assign refresh_window = x < REFRESH_CYCLES;

    assign vblank = line >= FRAME_LINES - VBLANK_LINES;

endmodule

`default_nettype wire

/* rtl/dram_arbiter.sv */
/*
 * Shares one SDRAM port between refresh reads and the CPU; refresh wins while its window is open.
 * The owner only changes while busy is low, and a strobe needs two idle cycles in a row.
 */
`timescale 1ns/1ps
`default_nettype none

module dram_arbiter
    import mcd_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire dram_req_t   dreq,
    input  wire logic        refresh_window,
    input  wire logic        sdram_busy,
    output logic [24:0]      sdram_addr,
    output logic             sdram_rd,
    output logic             sdram_wr,
    output logic             sdram_word,
    output logic [15:0]      sdram_din,
    output logic             ack
);

    owner_e      owner;
    owner_e      owner_q;
    owner_e      owner_next;
    logic        busy_q;
    logic        idle;
    logic        busy_fall;
    logic [24:0] last_read_addr;

    assign owner_next = refresh_window ? REFRESH : CPU;

    // frozen for the whole access
    assign owner = sdram_busy ? owner_q : owner_next;

    assign idle      = !sdram_busy && !busy_q;
    assign busy_fall = !sdram_busy && busy_q;

    // busy_q starts high so nothing is strobed or acknowledged
    // until the memory has been seen idle for a cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            owner_q <= REFRESH;
            busy_q  <= 1'b1;
        end else begin
            owner_q <= owner;
            busy_q  <= sdram_busy;
        end
    end

    always_ff @(posedge clk) begin
        if (sdram_rd) begin
            last_read_addr <= sdram_addr;
        end
    end

    always_comb begin
        sdram_addr = '0;
        sdram_rd   = 1'b0;
        sdram_wr   = 1'b0;
        sdram_word = 1'b0;

        case (owner)
            REFRESH: begin
                // rereading the same row keeps the SDRAM refreshed
                sdram_addr = last_read_addr;
                sdram_word = 1'b1;
                sdram_rd   = idle;
            end
            CPU: begin
                if (dreq.active) begin
                    sdram_addr = dreq.sdram_addr;
                    sdram_word = dreq.word;
                    // ROM writes arrive with write low and turn into reads
                    sdram_rd   = idle && !dreq.write;
                    sdram_wr   = idle && dreq.write;
                end
            end
            default: begin
                sdram_rd = 1'b0;
            end
        endcase
    end

    // only the CPU writes to SDRAM
    assign sdram_din = dreq.din;

    // an SDRAM access ends on the fall of busy, everything else is acked at once
    always_comb begin
        if (dreq.active) begin
            ack = busy_fall && owner_q == CPU;
        end else begin
            ack = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* rtl/cpu_bus_decode.sv */
/*
 * Memory map decode and SDRAM address formation; combinational apart from the boot counter.
 * Until four upper-byte accesses are acknowledged every selected access goes to ROM.
 */
`timescale 1ns/1ps
`default_nettype none

module cpu_bus_decode
    import mcd_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire cpu_req_t  req,
    input  wire logic      ack,
    output dram_req_t      dreq
);

    logic [2:0]  boot_cnt;
    logic        boot_rom;
    logic [22:0] byte_addr;
    logic        in_ram;
    logic        in_rom;
    logic        in_sysio;
    logic        in_ch2;
    logic        in_ch1;

    assign boot_rom = boot_cnt < BOOT_ROM_ACCESSES;

    // only acknowledged upper-byte accesses count towards the swap
    always_ff @(posedge clk) begin
        if (reset) begin
            boot_cnt <= 3'd0;
        end else if (req.cs && req.uds && boot_rom && ack) begin
            boot_cnt <= boot_cnt + 3'd1;
        end
    end

    assign byte_addr = {req.addr, 1'b0};

    assign in_ram   = byte_addr <= RAM_TOP;
    assign in_rom   = byte_addr >= ROM_BASE && byte_addr <= ROM_TOP;
    assign in_sysio = byte_addr >= SYSIO_BASE && byte_addr < CH2_BASE;
    assign in_ch2   = byte_addr >= CH2_BASE && byte_addr < CH1_BASE;
    assign in_ch1   = byte_addr >= CH1_BASE && byte_addr <= CH1_TOP;

    always_comb begin
        dreq = '0;
        dreq.din = req.din;

        if (!req.cs) begin
            dreq.target = T_NONE;
        end else if (boot_rom || in_rom) begin
            dreq.target = T_ROM;
        end else if (in_ram) begin
            dreq.target = T_RAM;
        end else if (in_ch1 && byte_addr[7:0] == STATUS_OFFSET) begin
            dreq.target = T_STATUS;
        end else if (in_sysio || in_ch2 || in_ch1) begin
            dreq.target = T_IO;
        end else begin
            dreq.target = T_NONE;
        end

        case (dreq.target)
            T_ROM: begin
                // ROM sits above the RAM image and is only ever read as words
                dreq.sdram_addr = {ROM_SDRAM_PREFIX, req.addr.rom_view.offset, 1'b0};
                dreq.word = 1'b1;
            end
            T_RAM: begin
                // bank select A18 becomes the top bit, then A21
                dreq.sdram_addr[24:1] = {5'b0, req.addr.ram_view.bank,
                                         req.addr.ram_view.a21, req.addr.ram_view.a17_1};
                // odd byte only on a lower-strobe write
                dreq.sdram_addr[0] = req.write && req.lds && !req.uds;
                dreq.word = (req.uds && req.lds) || !req.write;
                dreq.write = req.write;
            end
            default: begin
                dreq.sdram_addr = '0;
            end
        endcase

        dreq.active = (dreq.target == T_RAM || dreq.target == T_ROM) && (req.uds || req.lds);
    end

endmodule

`default_nettype wire

/* rtl/mcd_pkg.sv */
/*
 * Address map, line timer constants and request types shared by the DRAM front end.
 * Timer lengths are shortened for simulation and do not match a real video line.
 */
`default_nettype none

package mcd_pkg;

    // byte address bounds of the CPU memory map
    localparam logic [22:0] RAM_TOP    = 23'h3F_FFFF;
    localparam logic [22:0] ROM_BASE   = 23'h40_0000;
    localparam logic [22:0] ROM_TOP    = 23'h4F_FBFF;
    localparam logic [22:0] SYSIO_BASE = 23'h4F_FC00;
    localparam logic [22:0] CH2_BASE   = 23'h4F_FFE0;
    localparam logic [22:0] CH1_BASE   = 23'h4F_FFF0;
    localparam logic [22:0] CH1_TOP    = 23'h4F_FFFF;

    // channel 1 status register, low address byte
    localparam logic [7:0] STATUS_OFFSET = 8'hF0;
    localparam int STATUS_VBLANK_BIT = 7;

    localparam logic [2:0] BOOT_ROM_ACCESSES = 3'd4;
    localparam logic [2:0] ROM_SDRAM_PREFIX = 3'b001;

    // line timer, in clock cycles and lines
    localparam logic [7:0] LINE_CYCLES    = 8'd200;
    localparam logic [7:0] REFRESH_CYCLES = 8'd80;
    localparam logic [3:0] FRAME_LINES    = 4'd12;
    localparam logic [3:0] VBLANK_LINES   = 4'd2;

    // CPU word address, seen as a RAM address or as a ROM address
    typedef union packed {
        struct packed {
            logic        a22;
            logic        a21;
            logic [1:0]  a20_19;
            logic        bank;
            logic [16:0] a17_1;
        } ram_view;
        struct packed {
            logic        space;
            logic [20:0] offset;
        } rom_view;
    } cpu_addr_u;

    typedef struct packed {
        cpu_addr_u   addr;
        logic [15:0] din;
        logic        uds;
        logic        lds;
        logic        write;
        logic        cs;
    } cpu_req_t;

    // T_IO covers system I/O, channel 2 and channel 1 outside the status register
    typedef enum logic [2:0] {
        T_NONE,
        T_RAM,
        T_ROM,
        T_STATUS,
        T_IO
    } target_e;

    typedef struct packed {
        target_e     target;
        logic [24:0] sdram_addr;
        logic        word;
        logic        write;
        logic [15:0] din;
        logic        active;
    } dram_req_t;

    typedef enum logic {
        REFRESH,
        CPU
    } owner_e;

endpackage

`default_nettype wire
